// ==== design/divsqrt_pkg.sv ====
`default_nettype none

package divsqrt_pkg;

    // width of divide operands and of every result word
    localparam int data_w = 32;
    // width of the request tag that travels with each operation
    localparam int id_w = 4;
    // a square-root radicand is twice the result width
    localparam int rad_w = 2 * data_w;
    // iteration counter width, one step per result bit
    localparam int cnt_w = $clog2(data_w);

    typedef enum logic [1:0] {
        op_div  = 2'd0,
        op_rem  = 2'd1,
        op_sqrt = 2'd2
    } op_e;

    // divide view of the operand word, dividend in the upper half
    typedef struct packed {
        logic [data_w-1:0] dividend;
        logic [data_w-1:0] divisor;
    } div_operands_t;

    // the same 64-bit operand word is read as a pair or as one radicand
    typedef union packed {
        div_operands_t    div;
        logic [rad_w-1:0] radicand;
    } operand_u;

    typedef struct packed {
        op_e              op;
        logic [id_w-1:0]  id;
        operand_u         operands;
    } request_t;

    // dz flags a divide by zero and is never set for square roots
    typedef struct packed {
        logic [data_w-1:0] rd;
        logic [id_w-1:0]   id;
        logic              dz;
    } result_t;

endpackage

`default_nettype wire

// ==== design/divsqrt_issue.sv ====
`default_nettype none

module divsqrt_issue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          new_request,
    input  divsqrt_pkg::op_e              op,
    input  logic [divsqrt_pkg::id_w-1:0]  id,
    input  divsqrt_pkg::operand_u         operands,
    input  logic                          busy,
    input  logic                          wb_full,
    output logic                          ready,
    output logic                          start,
    output divsqrt_pkg::request_t         req
);

    // high for the one cycle between acceptance and the unit taking the request
    logic pending;
    logic accept;

    // no new work while a request waits, a unit is occupied,
    // or the writeback register still holds a result
    assign ready = ~pending & ~busy & ~wb_full;

    assign accept = new_request & ready;

    // the units load on the edge that ends the pending cycle,
    // so pending itself serves as the start pulse
    assign start = pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            // pending lasts exactly one cycle since accept needs it low
            pending <= accept;
        end
    end

    // the request payload is captured on acceptance and held for the start cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            req.op       <= op;
            req.id       <= id;
            req.operands <= operands;
        end
    end

endmodule

`default_nettype wire

// ==== design/int_div.sv ====
`default_nettype none

module int_div (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  divsqrt_pkg::request_t  req,
    input  logic                   ack,
    output logic                   done,
    output logic                   busy,
    output divsqrt_pkg::result_t   res
);
    import divsqrt_pkg::*;

    logic                running;
    logic [cnt_w-1:0]    count;
    // holds the dividend at start and collects quotient bits from the bottom
    logic [data_w-1:0]   quotient;
    logic [data_w-1:0]   rem;
    logic [data_w-1:0]   divisor;
    logic                is_rem;
    logic [id_w-1:0]     id;
    logic                dz;
    // partial remainder after bringing down the next dividend bit
    logic [data_w:0]     rem_shift;
    logic                fits;

    assign rem_shift = {rem, quotient[data_w-1]};
    assign fits      = rem_shift >= {1'b0, divisor};

    // the unit counts as occupied until its result has been taken
    assign busy = running | done;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            if (start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                // the last of the data_w iterations also raises done
                if (&count) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
            if (ack) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quotient <= req.operands.div.dividend;
            rem      <= '0;
            divisor  <= req.operands.div.divisor;
            is_rem   <= (req.op == op_rem);
            id       <= req.id;
            // with a zero divisor every trial subtract succeeds, leaving
            // all ones in the quotient and the dividend in the remainder
            dz       <= (req.operands.div.divisor == '0);
        end else if (running) begin
            quotient <= {quotient[data_w-2:0], fits};
            // a successful subtract leaves a value below the divisor,
            // so the low bits are all that is kept
            rem      <= fits ? rem_shift[data_w-1:0] - divisor : rem_shift[data_w-1:0];
        end
    end

    always_comb begin
        res.rd = is_rem ? rem : quotient;
        res.id = id;
        res.dz = dz;
    end

endmodule

`default_nettype wire

// ==== design/int_sqrt.sv ====
`default_nettype none

module int_sqrt (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  divsqrt_pkg::request_t  req,
    input  logic                   ack,
    output logic                   done,
    output logic                   busy,
    output divsqrt_pkg::result_t   res
);
    import divsqrt_pkg::*;

    logic                running;
    logic [cnt_w-1:0]    count;
    // radicand bits are consumed two at a time from the top
    logic [rad_w-1:0]    rad;
    logic [data_w-1:0]   root;
    // two's complement partial remainder whose sign picks add or subtract
    logic [data_w+3:0]   r;
    logic [data_w+3:0]   r_shift;
    logic [data_w+3:0]   r_next;
    logic [id_w-1:0]     id;

    // the dropped top bits are copies of the sign at this point
    assign r_shift = {r[data_w+1:0], rad[rad_w-1 -: 2]};

    always_comb begin
        // negative remainder restores through an add of 4q+3
        if (r[data_w+3]) begin
            r_next = r_shift + {2'b00, root, 2'b11};
        end else begin
            r_next = r_shift - {2'b00, root, 2'b01};
        end
    end

    assign busy = running | done;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            if (start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (&count) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
            if (ack) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rad  <= req.operands.radicand;
            r    <= '0;
            root <= '0;
            id   <= req.id;
        end else if (running) begin
            rad  <= {rad[rad_w-3:0], 2'b00};
            r    <= r_next;
            // a non-negative new remainder means the root bit is one
            root <= {root[data_w-2:0], ~r_next[data_w+3]};
        end
    end

    // the final remainder is not corrected since only the root is returned
    always_comb begin
        res.rd = root;
        res.id = id;
        res.dz = 1'b0;
    end

endmodule

`default_nettype wire

// ==== design/div_sqrt_wrapper.sv ====
`default_nettype none

module div_sqrt_wrapper (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  divsqrt_pkg::request_t  req,
    input  logic                   ack,
    output logic                   busy,
    output logic                   done,
    output divsqrt_pkg::result_t   res
);
    import divsqrt_pkg::*;

    logic     div_start;
    logic     sqrt_start;
    logic     div_ack;
    logic     sqrt_ack;
    logic     div_done;
    logic     sqrt_done;
    logic     div_busy;
    logic     sqrt_busy;
    result_t  div_res;
    result_t  sqrt_res;

    // divide and remainder share the divider, it latches which one to return
    assign sqrt_start = start & (req.op == op_sqrt);
    assign div_start  = start & (req.op != op_sqrt);

    // issue waits for both units, so only one is ever working
    assign busy = div_busy | sqrt_busy;

    int_div u_div (
        .clk   (clk),
        .rst   (rst),
        .start (div_start),
        .req   (req),
        .ack   (div_ack),
        .done  (div_done),
        .busy  (div_busy),
        .res   (div_res)
    );

    int_sqrt u_sqrt (
        .clk   (clk),
        .rst   (rst),
        .start (sqrt_start),
        .req   (req),
        .ack   (sqrt_ack),
        .done  (sqrt_done),
        .busy  (sqrt_busy),
        .res   (sqrt_res)
    );

    always_comb begin
        // each unit only sees an ack aimed at its own result
        div_ack  = ack & div_done;
        sqrt_ack = ack & sqrt_done;
        // divider first in the merge
        if (div_done) begin
            done = div_done;
            res  = div_res;
        end else begin
            done = sqrt_done;
            res  = sqrt_res;
        end
    end

endmodule

`default_nettype wire

// ==== design/divsqrt_wb.sv ====
`default_nettype none

module divsqrt_wb (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  unit_done,
    input  divsqrt_pkg::result_t  unit_res,
    input  logic                  ack,
    output logic                  unit_ack,
    output logic                  full,
    output logic                  done,
    output divsqrt_pkg::result_t  res
);

    // take the unit result only into an empty slot, which frees the unit
    // while the consumer may still be stalling
    assign unit_ack = unit_done & ~full;

    // a held result is always presented downstream
    assign done = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (unit_ack) begin
            full <= 1'b1;
        end else if (ack) begin
            // the consumer only acks while done is high
            full <= 1'b0;
        end
    end

    // result stays put while full, so it is stable under back-pressure
    always_ff @(posedge clk) begin
        if (unit_ack) begin
            res <= unit_res;
        end
    end

endmodule

`default_nettype wire

// ==== design/divsqrt_top.sv ====
`default_nettype none

module divsqrt_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          new_request,
    input  divsqrt_pkg::op_e              op,
    input  logic [divsqrt_pkg::id_w-1:0]  id,
    input  divsqrt_pkg::operand_u         operands,
    output logic                          ready,
    output logic                          done,
    input  logic                          ack,
    output divsqrt_pkg::result_t          res
);
    import divsqrt_pkg::*;

    logic      start;
    logic      busy;
    logic      wb_full;
    logic      unit_done;
    logic      unit_ack;
    request_t  req;
    result_t   unit_res;

    divsqrt_issue u_issue (
        .clk         (clk),
        .rst         (rst),
        .new_request (new_request),
        .op          (op),
        .id          (id),
        .operands    (operands),
        .busy        (busy),
        .wb_full     (wb_full),
        .ready       (ready),
        .start       (start),
        .req         (req)
    );

    div_sqrt_wrapper u_core (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .req   (req),
        .ack   (unit_ack),
        .busy  (busy),
        .done  (unit_done),
        .res   (unit_res)
    );

    divsqrt_wb u_wb (
        .clk       (clk),
        .rst       (rst),
        .unit_done (unit_done),
        .unit_res  (unit_res),
        .ack       (ack),
        .unit_ack  (unit_ack),
        .full      (wb_full),
        .done      (done),
        .res       (res)
    );

endmodule

`default_nettype wire

// ==== sim/tb_divsqrt.sv ====
`default_nettype none

module tb_divsqrt;
    import divsqrt_pkg::*;

    // request counts for the edge cases, random divides, random roots and the back-pressure phase
    localparam int n_edge = 25;
    localparam int n_rand_div = 40;
    localparam int n_rand_sqrt = 30;
    localparam int n_stall = 40;
    localparam int n_requests = n_edge + n_rand_div + n_rand_sqrt + n_stall;
    // 60 cycles per request leaves room for the 35-cycle latency and ack gaps
    localparam int watchdog_cycles = n_requests * 60 + 200;
    localparam int full_latency = 35;

    logic            clk;
    logic            rst;
    logic            new_request;
    op_e             op;
    logic [id_w-1:0] id;
    operand_u        operands;
    logic            ack;
    logic            ready;
    logic            done;
    result_t         res;

    logic [31:0]     lfsr;
    logic            stall_mode;
    logic [id_w-1:0] next_id;
    int              cycle = 0;
    int              issued;
    int              checked;
    // expected result, acceptance edge and exact-latency flag per request
    result_t         expected_q[$];
    int              stamp_q[$];
    bit              exact_q[$];
    logic            held;
    result_t         held_res;

    divsqrt_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .new_request (new_request),
        .op          (op),
        .id          (id),
        .operands    (operands),
        .ready       (ready),
        .done        (done),
        .ack         (ack),
        .res         (res)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // edge counter used to measure latency from acceptance to writeback
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // 32-bit Fibonacci register with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step of the register for every bit that is taken
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    // expected result from the operation rules with the dividend in the upper word
    function automatic result_t expected_result(input op_e o, input logic [63:0] word,
                                                input logic [id_w-1:0] tag);
        logic [31:0] dividend;
        logic [31:0] divisor;
        logic [31:0] root;
        logic [63:0] trial;
        result_t     r;
        dividend = word[63:32];
        divisor  = word[31:0];
        r.id = tag;
        r.dz = 1'b0;
        if (o == op_sqrt) begin
            // greedy bit search that keeps a root bit when its square still fits
            root = '0;
            for (int b = 31; b >= 0; b--) begin
                trial = {32'b0, root | (32'd1 << b)};
                if (trial * trial <= word) begin
                    root = root | (32'd1 << b);
                end
            end
            r.rd = root;
        end else if (divisor == '0) begin
            // RISC-V rule for a zero divisor
            r.dz = 1'b1;
            r.rd = (o == op_div) ? 32'hffff_ffff : dividend;
        end else begin
            r.rd = (o == op_div) ? dividend / divisor : dividend % divisor;
        end
        return r;
    endfunction

    // advance one cycle and drive the consumer ack just after the edge
    task automatic next_cycle();
        logic [63:0] bits;
        @(posedge clk);
        #1;
        if (stall_mode) begin
            // the consumer takes a result on about one cycle in four
            take_bits(2, bits);
            ack = (bits[1:0] == 2'b11);
        end else begin
            ack = 1'b1;
        end
    endtask

    task automatic send(input op_e o, input logic [63:0] word);
        while (!ready) begin
            next_cycle();
        end
        new_request = 1'b1;
        op          = o;
        id          = next_id;
        operands    = word;
        expected_q.push_back(expected_result(o, word, next_id));
        // the request is taken on the coming edge
        stamp_q.push_back(cycle + 1);
        exact_q.push_back(!stall_mode);
        next_id = next_id + 4'd1;
        issued++;
        next_cycle();
        new_request = 1'b0;
    endtask

    task automatic send_both(input logic [31:0] dividend, input logic [31:0] divisor);
        send(op_div, {dividend, divisor});
        send(op_rem, {dividend, divisor});
    endtask

    // wait until every issued request has come back
    task automatic drain();
        while (checked < issued) begin
            next_cycle();
        end
    endtask

    initial begin
        #(watchdog_cycles * 10);
        stop_with_failure($sformatf("the unit hung, only %0d of %0d results came back",
                                    checked, n_requests));
    end

    // the comparison process samples on the rising edge where outputs are settled
    initial begin
        result_t exp_res;
        int      stamp;
        int      latency;
        bit      exact;
        held     = 1'b0;
        held_res = '0;
        checked  = 0;
        forever begin
            @(posedge clk);
            if (!rst) begin
                // a result that was not taken must still be there unchanged
                if (held) begin
                    check_value("done while result is held", 64'(done), 64'd1);
                    check_value("held result", 64'(res), 64'(held_res));
                end
                if (done) begin
                    check_value("ready while writeback is full", 64'(ready), 64'd0);
                end
                if (done && ack) begin
                    if (expected_q.size() == 0) begin
                        stop_with_failure("a result came back with no request outstanding");
                    end
                    exp_res = expected_q.pop_front();
                    stamp   = stamp_q.pop_front();
                    exact   = exact_q.pop_front();
                    check_value("result rd", 64'(res.rd), 64'(exp_res.rd));
                    check_value("result id", 64'(res.id), 64'(exp_res.id));
                    check_value("result dz", 64'(res.dz), 64'(exp_res.dz));
                    latency = cycle + 1 - stamp;
                    if (exact) begin
                        check_value("latency", 64'(latency), 64'(full_latency));
                    end else begin
                        check_value("latency below minimum", 64'(latency < full_latency), 64'd0);
                    end
                    checked++;
                end
                held     = done && !ack;
                held_res = res;
            end
        end
    end

    // stimulus process
    initial begin
        logic [63:0] word;
        logic [63:0] sh;
        logic [63:0] sel;
        op_e         o;
        rst         = 1'b1;
        new_request = 1'b0;
        op          = op_div;
        id          = '0;
        operands    = '0;
        ack         = 1'b1;
        stall_mode  = 1'b0;
        lfsr        = 32'h9fac_46a3;
        next_id     = '0;
        issued      = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("ready after reset", 64'(ready), 64'd1);
        check_value("done after reset", 64'(done), 64'd0);

        // divide edge cases
        send_both(32'h1234_5678, 32'd1);
        send_both(32'd5, 32'd7);
        send_both(32'hffff_ffff, 32'hffff_ffff);
        send_both(32'hffff_ffff, 32'd1);
        send_both(32'd0, 32'd3);
        // zero divisors
        send_both(32'h1234_5678, 32'd0);
        send_both(32'd0, 32'd0);
        send_both(32'hffff_ffff, 32'd0);

        // square roots of zero, of small and large perfect squares and of all ones
        send(op_sqrt, 64'd0);
        send(op_sqrt, 64'd1);
        send(op_sqrt, 64'd2);
        send(op_sqrt, 64'd4);
        send(op_sqrt, 64'd144);
        send(op_sqrt, 64'h4000_0000_0000_0000);
        send(op_sqrt, 64'hffff_fffe_0000_0001);
        send(op_sqrt, 64'hffff_fffe_0000_0000);
        send(op_sqrt, 64'hffff_ffff_ffff_ffff);

        for (int i = 0; i < n_rand_div; i++) begin
            take_bits(64, word);
            take_bits(5, sh);
            // narrowing the divisor spreads quotients over their full range
            word[31:0] = word[31:0] >> sh[4:0];
            send((i % 2 == 0) ? op_div : op_rem, word);
        end

        for (int i = 0; i < n_rand_sqrt; i++) begin
            take_bits(64, word);
            take_bits(6, sh);
            send(op_sqrt, word >> sh[5:0]);
        end

        // the last result must be gone before ack starts to stall
        drain();
        stall_mode = 1'b1;
        for (int i = 0; i < n_stall; i++) begin
            take_bits(2, sel);
            take_bits(64, word);
            take_bits(5, sh);
            case (sel[1:0])
                2'd0: o = op_div;
                2'd1: o = op_rem;
                default: o = op_sqrt;
            endcase
            if (o == op_sqrt) begin
                word = word >> {sh[4:0], 1'b0};
            end else begin
                word[31:0] = word[31:0] >> sh[4:0];
            end
            send(o, word);
        end

        drain();
        // with ack held high a result that returns twice meets an empty queue
        stall_mode = 1'b0;
        ack        = 1'b1;
        repeat (full_latency + 5) begin
            next_cycle();
        end
        check_value("done when idle", 64'(done), 64'd0);
        check_value("ready when idle", 64'(ready), 64'd1);
        if (expected_q.size() != 0 || checked != n_requests) begin
            stop_with_failure($sformatf("%0d results checked of %0d requests",
                                        checked, n_requests));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/divsqrt_pkg.sv
design/divsqrt_issue.sv
design/int_div.sv
design/int_sqrt.sv
design/div_sqrt_wrapper.sv
design/divsqrt_wb.sv
design/divsqrt_top.sv
sim/tb_divsqrt.sv

// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module tb_divsqrt

# the run passes only when the simulation prints the pass message
sim:
	verilator --binary --timing -f project.f --top-module tb_divsqrt -o tb_divsqrt
	./obj_dir/tb_divsqrt | tee /dev/stderr | grep "TEST OK" > /dev/null

clean:
	rm -rf obj_dir
